//--- bench/ahb_stim.txt
// columns: op (0 read, 1 write), burst (0 SINGLE, 2 WRAP4), address, data0..data3, rsp stall
// data words past the burst length are ignored, read lines leave them at zero
1 0 00000040 cafe0040 00000000 00000000 00000000 0
0 0 00000040 00000000 00000000 00000000 00000000 0
1 2 00000028 11110028 1111002c 11110020 11110024 0
0 2 00000028 00000000 00000000 00000000 00000000 0
0 2 00000020 00000000 00000000 00000000 00000000 1
1 2 00000084 22220084 22220088 2222008c 22220080 1
1 2 000000bc 333300bc 333300b0 333300b4 333300b8 0
0 2 00000084 00000000 00000000 00000000 00000000 1
0 2 000000b0 00000000 00000000 00000000 00000000 1
1 0 000000f8 444400f8 00000000 00000000 00000000 1
0 0 000000f8 00000000 00000000 00000000 00000000 1
1 2 00000040 55550040 55550044 55550048 5555004c 1
0 0 00000040 00000000 00000000 00000000 00000000 1
0 2 0000004c 00000000 00000000 00000000 00000000 1
0 0 00000088 00000000 00000000 00000000 00000000 0
0 2 00000020 00000000 00000000 00000000 00000000 0

//--- list.f
design/ahb_pkg.sv
design/ahb_burst_sequencer.sv
design/ahb_master_ctrl.sv
design/ahb_sram_slave.sv
design/ahb_subsystem_top.sv
bench/ahb_subsystem_assertions.sv
bench/tb_ahb_subsystem.sv

//--- Bender.yml
package:
  name: ahb_subsystem

sources:
  - design/ahb_pkg.sv
  - design/ahb_burst_sequencer.sv
  - design/ahb_master_ctrl.sv
  - design/ahb_sram_slave.sv
  - design/ahb_subsystem_top.sv
  - target: simulation
    files:
      - bench/ahb_subsystem_assertions.sv
      - bench/tb_ahb_subsystem.sv

//--- bench/tb_ahb_subsystem.sv
`timescale 1ns/1ps

module tb_ahb_subsystem;

    localparam int unsigned MEM_WORDS   = 64;
    localparam int unsigned WAIT_STATES = 1;
    localparam int          FIELDS      = 8;    // words on one stim line
    localparam int          MAX_LINES   = 32;

    logic            clk;
    logic            rstn;
    logic            cmd_valid;
    logic            cmd_ready;
    logic            cmd_write;
    ahb_pkg::burst_t cmd_burst;
    logic [31:0]     cmd_addr;
    logic            wdata_valid;
    logic            wdata_ready;
    logic [31:0]     wdata;
    logic            rsp_valid;
    logic            rsp_ready;
    logic            rsp_write;
    logic [31:0]     rsp_addr;
    logic [31:0]     rsp_rdata;
    logic [31:0]     haddr;
    ahb_pkg::trans_t htrans;

    logic [31:0] stim [MAX_LINES*FIELDS];
    logic [31:0] ref_mem [MEM_WORDS];
    logic        written [MEM_WORDS];
    logic        exp_write [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] bus_addr [$];
    logic [1:0]  bus_trans [$];
    logic [2:0]  bus_burst [$];
    integer      seed = 32'h81a7_10e4;
    int          line_count = 0;
    int          cycle_count = 0;
    int          timeout_limit = 0;
    logic        stall_en = 1'b0;

    ahb_subsystem_top #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) DUT (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic halt_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        halt_run();
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, actual, expected);
            halt_run();
        end
    endtask

    // beat n of a burst sits at base + (start offset + 4n) mod 16
    function automatic logic [31:0] beat_address(input logic [31:0] start, input int n);
        logic [31:0] offset;
        offset = ((start & 32'hF) + n * ahb_pkg::BEAT_BYTES) % ahb_pkg::WRAP4_SPAN;
        return (start & ahb_pkg::WRAP4_MASK) + offset;
    endfunction

    function automatic int word_index(input logic [31:0] addr);
        return int'((addr >> 2) % MEM_WORDS);
    endfunction

    task automatic wait_for_cmd_ready();
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for_wdata_ready();
        @(negedge clk);
        while (!wdata_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_command(input int line);
        int              base;
        int              beats;
        int              gap;
        int              n;
        int              idx;
        logic            is_write;
        ahb_pkg::burst_t burst;
        logic [31:0]     addr;
        base     = line * FIELDS;
        is_write = stim[base][0];
        burst    = ahb_pkg::burst_t'(stim[base + 1][2:0]);
        addr     = stim[base + 2];
        beats    = (burst == ahb_pkg::WRAP4) ? 4 : 1;
        stall_en = stim[base + 7][0];
        if (stim[base] > 1 || (stim[base + 1] != 0 && stim[base + 1] != 2)) begin
            report_failure($sformatf("stim line %0d has an unknown operation or burst", line));
        end
        cmd_valid   = 1'b1;
        cmd_write   = is_write;
        cmd_burst   = burst;
        cmd_addr    = addr;
        wdata_valid = is_write;   // the first word travels with a write command
        wdata       = stim[base + 3];
        wait_for_cmd_ready();
        cmd_valid   = 1'b0;
        wdata_valid = 1'b0;
        for (n = 0; n < beats; n++) begin
            idx = word_index(beat_address(addr, n));
            exp_write.push_back(is_write);
            exp_addr.push_back(beat_address(addr, n));
            bus_addr.push_back(beat_address(addr, n));
            bus_trans.push_back((n == 0) ? 2'd2 : 2'd3);   // NONSEQ opens, SEQ follows
            bus_burst.push_back((beats == 4) ? 3'd2 : 3'd0);
            if (is_write) begin
                ref_mem[idx] = stim[base + 3 + n];
                written[idx] = 1'b1;
                exp_data.push_back(32'd0);
            end else begin
                exp_data.push_back(ref_mem[idx]);
            end
        end
        for (n = 1; n < beats && is_write; n++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            wdata_valid = 1'b1;
            wdata       = stim[base + 3 + n];
            wait_for_wdata_ready();
            wdata_valid = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        #1;
        if (stall_en) begin
            rsp_ready = ($random(seed) & 1) != 0;
        end else begin
            rsp_ready = 1'b1;
        end
    end

    always @(negedge clk) begin
        logic want_write;
        if (rstn && rsp_valid && rsp_ready) begin
            if (exp_addr.size() == 0) begin
                report_failure("a response came out with no beat outstanding");
            end
            want_write = exp_write.pop_front();
            check_value(rsp_write, want_write, "rsp_write");
            check_value(rsp_addr, exp_addr.pop_front(), "rsp_addr");
            if (!want_write) begin
                check_value(rsp_rdata, exp_data.pop_front(), "rsp_rdata");
            end else begin
                void'(exp_data.pop_front());
            end
        end
        if (rstn && cmd_ready && (exp_addr.size() != 0 || rsp_valid)) begin
            report_failure("cmd_ready is high while responses of a burst are still outstanding");
        end
    end

    // every address phase the slave accepts must be the next beat of the model
    always @(negedge clk) begin
        if (rstn && DUT.hready &&
            (htrans == ahb_pkg::NONSEQ || htrans == ahb_pkg::SEQ)) begin
            if (bus_addr.size() == 0) begin
                report_failure("an address phase appeared with no beat outstanding");
            end
            check_value(haddr, bus_addr.pop_front(), "haddr");
            check_value(htrans, bus_trans.pop_front(), "htrans");
            check_value(DUT.hburst, bus_burst.pop_front(), "hburst");
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            halt_run();
        end
        if (DUT.u_assertions.fail_count != 0) begin
            report_failure("an AHB protocol assertion failed");
        end
    end

    initial begin
        int line;
        rstn        = 1'b0;
        cmd_valid   = 1'b0;
        cmd_write   = 1'b0;
        cmd_burst   = ahb_pkg::SINGLE;
        cmd_addr    = '0;
        wdata_valid = 1'b0;
        wdata       = '0;
        rsp_ready   = 1'b0;
        foreach (stim[i]) stim[i] = '1;   // all ones marks the end of the command list
        foreach (written[i]) written[i] = 1'b0;
        $readmemh("bench/ahb_stim.txt", stim);
        while (line_count < MAX_LINES && stim[line_count * FIELDS] !== 32'hFFFF_FFFF) begin
            line_count++;
        end
        if (line_count == 0) begin
            report_failure("the stim file holds no command lines");
        end
        timeout_limit = line_count * 40 * (WAIT_STATES + 2) + 200;

        repeat (9) @(posedge clk);
        @(negedge clk);
        check_value(cmd_ready, 0, "cmd_ready in reset");
        check_value(wdata_ready, 0, "wdata_ready in reset");
        check_value(rsp_valid, 0, "rsp_valid in reset");
        check_value(htrans, ahb_pkg::IDLE, "htrans in reset");
        @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_value(cmd_ready, 0, "cmd_ready right after reset");
        wait_for_cmd_ready();   // rises with no command pending

        for (line = 0; line < line_count; line++) begin
            run_command(line);
        end
        while (exp_addr.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(negedge clk);
        check_value(rsp_valid, 0, "rsp_valid after the last burst");
        check_value(bus_addr.size(), 0, "address phases still missing");
        foreach (ref_mem[i]) begin
            if (written[i]) begin
                check_value(DUT.u_slave.mem[i], ref_mem[i], $sformatf("memory word %0d", i));
            end
        end

        if (DUT.u_assertions.fail_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "AHB protocol assertions failed");
        end
    end

endmodule

//--- bench/ahb_subsystem_assertions.sv
`timescale 1ns/1ps

module ahb_subsystem_assertions (
    input logic            clk,
    input logic            rstn,
    input logic [31:0]     haddr,
    input ahb_pkg::trans_t htrans,
    input logic            hready,
    input logic            rsp_valid,
    input logic            rsp_ready,
    input logic            rsp_write,
    input logic [31:0]     rsp_addr,
    input logic [31:0]     rsp_rdata
);

    int unsigned fail_count = 0;

    // a wait state freezes the pending address phase
    property addr_held_in_wait;
        @(posedge clk) disable iff (!rstn)
            !hready |=> ($stable(haddr) && $stable(htrans));
    endproperty

    property no_seq_after_idle;
        @(posedge clk) disable iff (!rstn)
            (htrans == ahb_pkg::IDLE) |=> (htrans != ahb_pkg::SEQ);
    endproperty

    property rsp_held_when_stalled;
        @(posedge clk) disable iff (!rstn)
            (rsp_valid && !rsp_ready) |=>
                (rsp_valid && $stable(rsp_write) && $stable(rsp_addr) && $stable(rsp_rdata));
    endproperty

    addr_held_chk: assert property (addr_held_in_wait)
        else begin
            fail_count++;
            $error("haddr or htrans changed while hready was low");
        end

    seq_order_chk: assert property (no_seq_after_idle)
        else begin
            fail_count++;
            $error("SEQ transfer followed an IDLE cycle");
        end

    rsp_stable_chk: assert property (rsp_held_when_stalled)
        else begin
            fail_count++;
            $error("response payload changed while stalled");
        end

endmodule

bind ahb_subsystem_top ahb_subsystem_assertions u_assertions (
    .clk       (clk),
    .rstn      (rstn),
    .haddr     (haddr),
    .htrans    (htrans),
    .hready    (hready),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_write (rsp_write),
    .rsp_addr  (rsp_addr),
    .rsp_rdata (rsp_rdata)
);

//--- design/ahb_subsystem_top.sv
`timescale 1ns/1ps

module ahb_subsystem_top #(
    parameter int unsigned MEM_WORDS   = 64,
    parameter int unsigned WAIT_STATES = 1
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            cmd_valid,
    output logic            cmd_ready,
    input  logic            cmd_write,
    input  ahb_pkg::burst_t cmd_burst,
    input  logic [31:0]     cmd_addr,
    input  logic            wdata_valid,
    output logic            wdata_ready,
    input  logic [31:0]     wdata,
    output logic            rsp_valid,
    input  logic            rsp_ready,
    output logic            rsp_write,
    output logic [31:0]     rsp_addr,
    output logic [31:0]     rsp_rdata,
    output logic [31:0]     haddr,
    output ahb_pkg::trans_t htrans
);

    logic            hwrite;
    ahb_pkg::burst_t hburst;
    logic [31:0]     hwdata;
    logic [31:0]     hrdata;
    logic            hready;

    ahb_master_ctrl u_master (
        .clk         (clk),
        .rstn        (rstn),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_write   (cmd_write),
        .cmd_burst   (cmd_burst),
        .cmd_addr    (cmd_addr),
        .wdata_valid (wdata_valid),
        .wdata_ready (wdata_ready),
        .wdata       (wdata),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp_write   (rsp_write),
        .rsp_addr    (rsp_addr),
        .rsp_rdata   (rsp_rdata),
        .haddr       (haddr),
        .htrans      (htrans),
        .hwrite      (hwrite),
        .hburst      (hburst),
        .hwdata      (hwdata),
        .hrdata      (hrdata),
        .hready      (hready)
    );

    ahb_sram_slave #(
        .MEM_WORDS   (MEM_WORDS),
        .WAIT_STATES (WAIT_STATES)
    ) u_slave (
        .clk    (clk),
        .rstn   (rstn),
        .haddr  (haddr),
        .htrans (htrans),
        .hwrite (hwrite),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hready (hready)
    );

endmodule

//--- design/ahb_sram_slave.sv
`timescale 1ns/1ps

module ahb_sram_slave #(
    parameter int unsigned MEM_WORDS   = 64,
    parameter int unsigned WAIT_STATES = 1
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic [31:0]     haddr,
    input  ahb_pkg::trans_t htrans,
    input  logic            hwrite,
    input  logic [31:0]     hwdata,
    output logic [31:0]     hrdata,
    output logic            hready
);

    localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CW = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [31:0]   mem [MEM_WORDS];
    logic [AW-1:0] addr_index;
    logic [AW-1:0] dp_index_q;
    logic          dp_write_q;
    logic          dp_active_q;
    logic [CW-1:0] wait_cnt_q;    // wait cycles left in the current data phase
    logic          addr_taken;

    assign addr_index = AW'((haddr >> 2) % MEM_WORDS); // word index wraps at the memory depth
    assign addr_taken = hready && ((htrans == ahb_pkg::NONSEQ) || (htrans == ahb_pkg::SEQ));

    // hready only drops inside a data phase that still has wait cycles to serve
    assign hready = (wait_cnt_q == '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dp_active_q <= 1'b0;
            wait_cnt_q  <= '0;
        end else if (addr_taken) begin
            dp_active_q <= 1'b1;
            wait_cnt_q  <= CW'(WAIT_STATES);
        end else if (hready) begin
            dp_active_q <= 1'b0;
        end else begin
            wait_cnt_q <= wait_cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_taken) begin
            dp_index_q <= addr_index;
            dp_write_q <= hwrite;
        end
        if (dp_active_q && hready && dp_write_q) begin
            mem[dp_index_q] <= hwdata;
        end
    end

    assign hrdata = mem[dp_index_q];

endmodule

//--- design/ahb_master_ctrl.sv
`timescale 1ns/1ps

module ahb_master_ctrl (
    input  logic            clk,
    input  logic            rstn,
    input  logic            cmd_valid,
    output logic            cmd_ready,
    input  logic            cmd_write,
    input  ahb_pkg::burst_t cmd_burst,
    input  logic [31:0]     cmd_addr,
    input  logic            wdata_valid,
    output logic            wdata_ready,
    input  logic [31:0]     wdata,
    output logic            rsp_valid,
    input  logic            rsp_ready,
    output logic            rsp_write,
    output logic [31:0]     rsp_addr,
    output logic [31:0]     rsp_rdata,
    output logic [31:0]     haddr,
    output ahb_pkg::trans_t htrans,
    output logic            hwrite,
    output ahb_pkg::burst_t hburst,
    output logic [31:0]     hwdata,
    input  logic [31:0]     hrdata,
    input  logic            hready
);

    localparam int RSP_DEPTH = 4;

    logic            alive_q;        // rises one cycle after reset is released
    logic [2:0]      beats_pend_q;   // data phases of the current burst not yet finished
    logic            write_q;
    ahb_pkg::burst_t burst_q;
    logic [31:0]     word_q;         // write word for the beat on the address bus

    logic            dp_valid_q;
    logic            dp_write_q;
    logic [31:0]     dp_addr_q;
    logic [31:0]     hwdata_q;

    logic            rsp_write_mem [RSP_DEPTH];
    logic [31:0]     rsp_addr_mem  [RSP_DEPTH];
    logic [31:0]     rsp_data_mem  [RSP_DEPTH];
    logic [1:0]      wr_ptr_q;
    logic [1:0]      rd_ptr_q;
    logic [2:0]      rsp_count_q;

    logic busy;
    logic idle_room;
    logic cmd_accept;
    logic seq_advance;
    logic seq_hold;
    logic seq_last;
    logic beat_issue;
    logic next_beat_due;
    logic wdata_take;
    logic dp_done;
    logic rsp_pop;

    assign busy      = (beats_pend_q != 3'd0);
    assign idle_room = alive_q && !busy && (rsp_count_q == 3'd0); // all four entries free

    // a write is only taken together with its first word, so NONSEQ never waits for data
    assign cmd_ready  = idle_room && (!cmd_write || wdata_valid);
    assign cmd_accept = cmd_valid && cmd_ready;

    assign beat_issue    = hready && ((htrans == ahb_pkg::NONSEQ) || (htrans == ahb_pkg::SEQ));
    assign seq_advance   = hready && (htrans != ahb_pkg::IDLE);
    assign seq_hold      = write_q && !wdata_valid;
    assign next_beat_due = busy && write_q && hready &&
                           ((htrans == ahb_pkg::BUSY) || (beat_issue && !seq_last));

    assign wdata_ready = (idle_room && cmd_valid && cmd_write) || next_beat_due;
    assign wdata_take  = wdata_valid && wdata_ready;

    assign dp_done = dp_valid_q && hready;
    assign rsp_pop = rsp_valid && rsp_ready;

    ahb_burst_sequencer u_sequencer (
        .clk        (clk),
        .rstn       (rstn),
        .start      (cmd_accept),
        .start_addr (cmd_addr),
        .burst      (cmd_burst),
        .advance    (seq_advance),
        .hold       (seq_hold),
        .haddr      (haddr),
        .htrans     (htrans),
        .last_beat  (seq_last)
    );

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            alive_q      <= 1'b0;
            beats_pend_q <= '0;
            write_q      <= 1'b0;
            burst_q      <= ahb_pkg::SINGLE;
            dp_valid_q   <= 1'b0;
        end else begin
            alive_q <= 1'b1;
            if (cmd_accept) begin
                beats_pend_q <= ahb_pkg::burst_beats(cmd_burst);
                write_q      <= cmd_write;
                burst_q      <= cmd_burst;
            end else if (dp_done) begin
                beats_pend_q <= beats_pend_q - 3'd1;
            end
            if (beat_issue) begin
                dp_valid_q <= 1'b1;
            end else if (hready) begin
                dp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wdata_take) begin
            word_q <= wdata;
        end
        if (beat_issue) begin
            dp_write_q <= write_q;
            dp_addr_q  <= haddr;
            hwdata_q   <= word_q;
        end
    end

    // response buffer, space for a whole burst is reserved when the command is taken
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            rsp_count_q <= '0;
        end else begin
            if (dp_done) begin
                wr_ptr_q <= wr_ptr_q + 2'd1;
            end
            if (rsp_pop) begin
                rd_ptr_q <= rd_ptr_q + 2'd1;
            end
            rsp_count_q <= rsp_count_q + 3'(dp_done) - 3'(rsp_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (dp_done) begin
            rsp_write_mem[wr_ptr_q] <= dp_write_q;
            rsp_addr_mem[wr_ptr_q]  <= dp_addr_q;
            rsp_data_mem[wr_ptr_q]  <= dp_write_q ? 32'd0 : hrdata; // writes report the address only
        end
    end

    assign rsp_valid = (rsp_count_q != 3'd0);
    assign rsp_write = rsp_write_mem[rd_ptr_q];
    assign rsp_addr  = rsp_addr_mem[rd_ptr_q];
    assign rsp_rdata = rsp_data_mem[rd_ptr_q];

    assign hwrite = write_q;
    assign hburst = burst_q;
    assign hwdata = hwdata_q;

endmodule

//--- design/ahb_burst_sequencer.sv
`timescale 1ns/1ps

module ahb_burst_sequencer (
    input  logic            clk,
    input  logic            rstn,
    input  logic            start,
    input  logic [31:0]     start_addr,
    input  ahb_pkg::burst_t burst,
    input  logic            advance,
    input  logic            hold,
    output logic [31:0]     haddr,
    output ahb_pkg::trans_t htrans,
    output logic            last_beat
);

    logic [31:0]     base_q;
    logic [3:0]      offset_q;
    logic [2:0]      beats_left_q;   // beats still to issue after the one on the bus
    ahb_pkg::trans_t trans_q;

    logic [31:0]     base_d;
    logic [3:0]      offset_d;
    logic [2:0]      beats_left_d;
    ahb_pkg::trans_t trans_d;

    logic [3:0]      offset_next;
    logic            addr_phase;

    assign addr_phase = (trans_q == ahb_pkg::NONSEQ) || (trans_q == ahb_pkg::SEQ);

    // the offset walks around the 16-byte block, so beat n sits at base + (offset + 4n) mod 16
    assign offset_next = 4'((32'(offset_q) + ahb_pkg::BEAT_BYTES) % ahb_pkg::WRAP4_SPAN);

    always_comb begin
        base_d       = base_q;
        offset_d     = offset_q;
        beats_left_d = beats_left_q;
        trans_d      = trans_q;

        if (start) begin
            base_d       = start_addr & ahb_pkg::WRAP4_MASK;
            offset_d     = start_addr[3:0];
            beats_left_d = ahb_pkg::burst_beats(burst) - 3'd1;
            trans_d      = ahb_pkg::NONSEQ;
        end else if (advance) begin
            case (trans_q)
                ahb_pkg::BUSY: begin
                    // address already points at the waiting beat
                    trans_d = hold ? ahb_pkg::BUSY : ahb_pkg::SEQ;
                end
                ahb_pkg::NONSEQ, ahb_pkg::SEQ: begin
                    if (beats_left_q == 3'd0) begin
                        trans_d = ahb_pkg::IDLE;
                    end else begin
                        offset_d     = offset_next;
                        beats_left_d = beats_left_q - 3'd1;
                        trans_d      = hold ? ahb_pkg::BUSY : ahb_pkg::SEQ;
                    end
                end
                default: begin
                    trans_d = ahb_pkg::IDLE;
                end
            endcase
        end
    end

    // every update happens on start or on an hready-high edge, so the bus holds during waits
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            base_q       <= '0;
            offset_q     <= '0;
            beats_left_q <= '0;
            trans_q      <= ahb_pkg::IDLE;
        end else begin
            base_q       <= base_d;
            offset_q     <= offset_d;
            beats_left_q <= beats_left_d;
            trans_q      <= trans_d;
        end
    end

    assign haddr     = base_q | {28'd0, offset_q};
    assign htrans    = trans_q;
    assign last_beat = addr_phase && (beats_left_q == 3'd0); // final NONSEQ or SEQ of the burst

endmodule

//--- design/ahb_pkg.sv
package ahb_pkg;

    // HBURST values, only the two burst kinds this master issues
    typedef enum logic [2:0] {
        SINGLE = 3'd0,
        WRAP4  = 3'd2
    } burst_t;

    // HTRANS values as defined by AHB-Lite
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        BUSY   = 2'd1,
        NONSEQ = 2'd2,
        SEQ    = 2'd3
    } trans_t;

    localparam logic [31:0] WRAP4_MASK = 32'hFFFF_FFF0; // clears the offset inside a 16-byte block
    localparam logic [31:0] WRAP4_SPAN = 32'd16;        // four beats of one word each
    localparam logic [31:0] BEAT_BYTES = 32'd4;         // every beat moves one 32-bit word

    // number of beats a burst carries
    function automatic logic [2:0] burst_beats(burst_t burst);
        logic [2:0] beats;
        case (burst)
            WRAP4:   beats = 3'd4;
            default: beats = 3'd1;
        endcase
        return beats;
    endfunction

endpackage
